// File: filelist.f
+incdir+tests
hw/soc_pkg.sv
hw/obi_priority_mux.sv
hw/addr_decoder.sv
hw/sram_bank.sv
hw/gpio_regs.sv
hw/response_mux.sv
hw/soc_fabric_top.sv
tests/tb_soc_fabric.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       := tb_soc_fabric
FILELIST  := filelist.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The binary's exit status is hidden by the pipe, the log decides
sim: build
	rm -f $(LOG)
	-$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^TEST OK$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tests/tb_tasks.svh
//////////////////////////////////////////////////
// Compare tasks
//////////////////////////////////////////////////

task automatic stop_on_error();
    $display("TEST FAILED");
    $fatal(1, "stopping at the first mismatch");
endtask

task automatic check_word(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                          input string what);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s, got 0x%08h, expected 0x%08h", $time, what, got, exp);
        stop_on_error();
    end
endtask

task automatic check_gpio(input logic [NUM_GPIO-1:0] got, input logic [NUM_GPIO-1:0] exp,
                          input string what);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s, got 0x%06h, expected 0x%06h", $time, what, got, exp);
        stop_on_error();
    end
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, what, got, exp);
        stop_on_error();
    end
endtask

//////////////////////////////////////////////////
// Bus drivers
//////////////////////////////////////////////////

task automatic drive_port(input logic is_host, input logic req, input logic [DATA_W-1:0] addr,
                          input logic we, input logic [BE_W-1:0] be,
                          input logic [DATA_W-1:0] wdata);
    if (is_host) begin
        host_req   = req;
        host_addr  = addr;
        host_we    = we;
        host_be    = be;
        host_wdata = wdata;
    end else begin
        core_req   = req;
        core_addr  = addr;
        core_we    = we;
        core_be    = be;
        core_wdata = wdata;
    end
endtask

// Holds req until gnt, then expects rvalid on the very next cycle
task automatic run_access(input logic is_host, input logic [DATA_W-1:0] addr, input logic we,
                          input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wdata,
                          output logic [DATA_W-1:0] rdata);
    logic gnt;
    @(posedge clk);
    #1;
    drive_port(is_host, 1'b1, addr, we, be, wdata);
    do begin
        @(negedge clk);
        gnt = is_host ? host_gnt : core_gnt;
        check_bit(is_host ? host_rvalid : core_rvalid, 1'b0, "rvalid before acceptance");
    end while (!gnt);
    @(posedge clk);
    #1;
    drive_port(is_host, 1'b0, '0, 1'b0, '0, '0);
    @(negedge clk);
    check_bit(is_host ? host_rvalid : core_rvalid, 1'b1, "rvalid one cycle after acceptance");
    rdata = is_host ? host_rdata : core_rdata;
endtask

task automatic bus_write(input logic is_host, input logic [DATA_W-1:0] addr,
                         input logic [BE_W-1:0] be, input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] rdata;
    run_access(is_host, addr, 1'b1, be, wdata, rdata);
    check_word(rdata, '0, "write response data");
endtask

task automatic bus_read(input logic is_host, input logic [DATA_W-1:0] addr,
                        output logic [DATA_W-1:0] rdata);
    run_access(is_host, addr, 1'b0, '1, '0, rdata);
endtask

// File: tests/tb_soc_fabric.sv
`timescale 1ns/1ps

module tb_soc_fabric;
    import soc_pkg::*;

    localparam int unsigned SRAM_WORDS = 256;
    localparam int unsigned NUM_GPIO   = 24;
    // The whole sequence needs about 100 cycles
    localparam int unsigned WATCHDOG_CYCLES = 2000;

    logic                clk = 1'b0;
    logic                rst_n;
    logic                host_en;
    logic                core_req, core_gnt, core_we, core_rvalid;
    logic [DATA_W-1:0]   core_addr, core_wdata, core_rdata;
    logic [BE_W-1:0]     core_be;
    logic                host_req, host_gnt, host_we, host_rvalid;
    logic [DATA_W-1:0]   host_addr, host_wdata, host_rdata;
    logic [BE_W-1:0]     host_be;
    logic [NUM_GPIO-1:0] gpio_in, gpio_out, gpio_oeb_n;

    soc_fabric_top #(
        .SRAM_WORDS (SRAM_WORDS),
        .NUM_GPIO   (NUM_GPIO)
    ) uut (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .host_en_i     (host_en),
        .core_req_i    (core_req),
        .core_gnt_o    (core_gnt),
        .core_addr_i   (core_addr),
        .core_we_i     (core_we),
        .core_be_i     (core_be),
        .core_wdata_i  (core_wdata),
        .core_rvalid_o (core_rvalid),
        .core_rdata_o  (core_rdata),
        .host_req_i    (host_req),
        .host_gnt_o    (host_gnt),
        .host_addr_i   (host_addr),
        .host_we_i     (host_we),
        .host_be_i     (host_be),
        .host_wdata_i  (host_wdata),
        .host_rvalid_o (host_rvalid),
        .host_rdata_o  (host_rdata),
        .gpio_i        (gpio_in),
        .gpio_o        (gpio_out),
        .gpio_oeb_no   (gpio_oeb_n)
    );

    always #4 clk = ~clk;

    `include "tb_tasks.svh"

    // Expected word after a byte-enabled write
    function automatic logic [DATA_W-1:0] merge_bytes(input logic [DATA_W-1:0] old_word,
                                                     input logic [DATA_W-1:0] new_word,
                                                     input logic [BE_W-1:0] be);
        logic [DATA_W-1:0] result;
        result = old_word;
        for (int b = 0; b < BE_W; b++) begin
            if (be[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    //////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////

    task automatic test_reset_state();
        logic [DATA_W-1:0] rd;
        check_gpio(gpio_out, '0, "gpio_o after reset");
        check_gpio(gpio_oeb_n, '1, "gpio_oeb_no after reset");
        check_bit(core_rvalid, 1'b0, "core rvalid after reset");
        check_bit(host_rvalid, 1'b0, "host rvalid after reset");
        bus_read(1'b0, PERIPH_BASE + 32'(REG_ERR_COUNT), rd);
        check_word(rd, '0, "error count after reset");
    endtask

    task automatic test_sram_bytes();
        logic [DATA_W-1:0] model [8];
        logic [DATA_W-1:0] rd;
        logic [DATA_W-1:0] patch;
        for (int i = 0; i < 8; i++) begin
            model[i] = $urandom();
            bus_write(1'b0, SRAM_BASE + 32'(i * 8), 4'hF, model[i]);
        end
        for (int i = 0; i < 8; i++) begin
            bus_read(1'b0, SRAM_BASE + 32'(i * 8), rd);
            check_word(rd, model[i], "SRAM read-back");
        end
        patch = $urandom();
        bus_write(1'b0, SRAM_BASE + 32'h10, 4'b0101, patch);
        bus_read(1'b0, SRAM_BASE + 32'h10, rd);
        check_word(rd, merge_bytes(model[2], patch, 4'b0101), "SRAM partial write");
    endtask

    task automatic test_host_remap();
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] rd;
        data = $urandom();
        bus_write(1'b1, 32'h3000_0040, 4'hF, data);
        bus_read(1'b0, 32'h8000_0040, rd);
        check_word(rd, data, "core view of remapped host write");
        bus_read(1'b1, 32'h3000_0040, rd);
        check_word(rd, data, "host read through remap");
    endtask

    task automatic test_priority();
        logic [DATA_W-1:0] data_h;
        logic [DATA_W-1:0] data_c;
        data_h = $urandom();
        data_c = $urandom();
        bus_write(1'b1, 32'h3000_0080, 4'hF, data_h);
        bus_write(1'b0, 32'h8000_0084, 4'hF, data_c);
        // Both ports ask in the same cycle
        @(posedge clk);
        #1;
        drive_port(1'b1, 1'b1, 32'h3000_0080, 1'b0, 4'hF, '0);
        drive_port(1'b0, 1'b1, 32'h8000_0084, 1'b0, 4'hF, '0);
        @(negedge clk);
        check_bit(host_gnt, 1'b1, "host gnt when both request");
        check_bit(core_gnt, 1'b0, "core gnt when both request");
        @(posedge clk);
        #1;
        drive_port(1'b1, 1'b0, '0, 1'b0, '0, '0);
        @(negedge clk);
        check_bit(host_rvalid, 1'b1, "host rvalid after priority grant");
        check_word(host_rdata, data_h, "host rdata after priority grant");
        check_bit(core_gnt, 1'b1, "core gnt once host is idle");
        check_bit(core_rvalid, 1'b0, "core rvalid while waiting");
        @(posedge clk);
        #1;
        drive_port(1'b0, 1'b0, '0, 1'b0, '0, '0);
        @(negedge clk);
        check_bit(core_rvalid, 1'b1, "core rvalid after late grant");
        check_word(core_rdata, data_c, "core rdata after late grant");
        check_bit(host_rvalid, 1'b0, "host rvalid during core response");
    endtask

    task automatic test_enable_gate();
        logic [DATA_W-1:0] data;
        logic [DATA_W-1:0] rd;
        data = $urandom();
        bus_write(1'b0, 32'h8000_0100, 4'hF, data);
        @(posedge clk);
        #1;
        host_en = 1'b0;
        drive_port(1'b1, 1'b1, 32'h8000_0100, 1'b1, 4'hF, ~data);
        repeat (10) begin
            @(negedge clk);
            check_bit(host_gnt, 1'b0, "host gnt while disabled");
        end
        // Core still served with the gated host request pending
        bus_read(1'b0, 32'h8000_0100, rd);
        check_word(rd, data, "core read with host disabled");
        check_bit(host_gnt, 1'b0, "host gnt after core access");
        @(posedge clk);
        #1;
        drive_port(1'b1, 1'b0, '0, 1'b0, '0, '0);
        host_en = 1'b1;
    endtask

    task automatic test_gpio();
        logic [DATA_W-1:0]   out_val;
        logic [DATA_W-1:0]   oeb_val;
        logic [NUM_GPIO-1:0] pins;
        logic [DATA_W-1:0]   rd;
        out_val = $urandom();
        oeb_val = $urandom();
        pins    = NUM_GPIO'($urandom());
        bus_write(1'b0, PERIPH_BASE + 32'(REG_GPIO_OUT), 4'hF, out_val);
        check_gpio(gpio_out, out_val[NUM_GPIO-1:0], "gpio_o after write");
        bus_write(1'b1, PERIPH_BASE + 32'(REG_GPIO_OEB), 4'hF, oeb_val);
        check_gpio(gpio_oeb_n, oeb_val[NUM_GPIO-1:0], "gpio_oeb_no after write");
        bus_read(1'b0, PERIPH_BASE + 32'(REG_GPIO_OUT), rd);
        check_word(rd, DATA_W'(out_val[NUM_GPIO-1:0]), "GPIO_OUT read-back");
        @(posedge clk);
        #1;
        gpio_in = pins;
        bus_read(1'b0, PERIPH_BASE + 32'(REG_GPIO_IN), rd);
        check_word(rd, DATA_W'(pins), "GPIO_IN read");
    endtask

    task automatic test_illegal();
        logic [DATA_W-1:0] rd;
        bus_read(1'b0, 32'h1000_0000, rd);
        check_word(rd, ERR_RDATA, "core illegal read data");
        bus_write(1'b1, 32'h1000_0000, 4'hF, $urandom());
        bus_read(1'b1, 32'h1000_0000, rd);
        check_word(rd, ERR_RDATA, "host illegal read data");
        bus_read(1'b0, PERIPH_BASE + 32'(REG_ERR_COUNT), rd);
        check_word(rd, 32'd3, "error count after three illegal accesses");
    endtask

    task automatic test_response_timing();
        @(posedge clk);
        #1;
        drive_port(1'b0, 1'b1, SRAM_BASE, 1'b0, 4'hF, '0);
        @(negedge clk);
        check_bit(core_gnt, 1'b1, "gnt in the request cycle");
        check_bit(core_rvalid, 1'b0, "rvalid in the accept cycle");
        @(posedge clk);
        #1;
        drive_port(1'b0, 1'b0, '0, 1'b0, '0, '0);
        @(negedge clk);
        check_bit(core_rvalid, 1'b1, "rvalid one cycle later");
        @(negedge clk);
        check_bit(core_rvalid, 1'b0, "rvalid is a single pulse");
    endtask

    //////////////////////////////////////////////////
    // Watchdog and main sequence
    //////////////////////////////////////////////////

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: tests did not finish");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(1));
        rst_n   = 1'b0;
        host_en = 1'b1;
        gpio_in = '0;
        drive_port(1'b0, 1'b0, '0, 1'b0, '0, '0);
        drive_port(1'b1, 1'b0, '0, 1'b0, '0, '0);
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_reset_state();
        test_sram_bytes();
        test_host_remap();
        test_priority();
        test_enable_gate();
        test_gpio();
        test_illegal();
        test_response_timing();

        $display("TEST OK");
        $finish;
    end

endmodule

// File: hw/soc_fabric_top.sv
`timescale 1ns/1ps

module soc_fabric_top #(
    parameter int unsigned SRAM_WORDS = 256,
    parameter int unsigned NUM_GPIO   = 24
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  logic                       host_en_i,

    // Core data port
    input  logic                       core_req_i,
    output logic                       core_gnt_o,
    input  logic [soc_pkg::DATA_W-1:0] core_addr_i,
    input  logic                       core_we_i,
    input  logic [soc_pkg::BE_W-1:0]   core_be_i,
    input  logic [soc_pkg::DATA_W-1:0] core_wdata_i,
    output logic                       core_rvalid_o,
    output logic [soc_pkg::DATA_W-1:0] core_rdata_o,

    // Host port
    input  logic                       host_req_i,
    output logic                       host_gnt_o,
    input  logic [soc_pkg::DATA_W-1:0] host_addr_i,
    input  logic                       host_we_i,
    input  logic [soc_pkg::BE_W-1:0]   host_be_i,
    input  logic [soc_pkg::DATA_W-1:0] host_wdata_i,
    output logic                       host_rvalid_o,
    output logic [soc_pkg::DATA_W-1:0] host_rdata_o,

    // GPIO pads, output enables active low
    input  logic [NUM_GPIO-1:0]        gpio_i,
    output logic [NUM_GPIO-1:0]        gpio_o,
    output logic [NUM_GPIO-1:0]        gpio_oeb_no
);
    import soc_pkg::*;

    logic              win_req, win_host, win_we;
    logic [DATA_W-1:0] win_addr, win_wdata;
    logic [BE_W-1:0]   win_be;

    logic              sram_req, gpio_req, illegal;
    logic [DATA_W-1:0] sram_rdata, gpio_rdata;

    //////////////////////////////////////////////////
    // Arbitration and decode
    //////////////////////////////////////////////////

    obi_priority_mux i_obi_priority_mux (
        .host_en_i    (host_en_i),
        .core_req_i   (core_req_i),
        .core_gnt_o   (core_gnt_o),
        .core_addr_i  (core_addr_i),
        .core_we_i    (core_we_i),
        .core_be_i    (core_be_i),
        .core_wdata_i (core_wdata_i),
        .host_req_i   (host_req_i),
        .host_gnt_o   (host_gnt_o),
        .host_addr_i  (host_addr_i),
        .host_we_i    (host_we_i),
        .host_be_i    (host_be_i),
        .host_wdata_i (host_wdata_i),
        .win_req_o    (win_req),
        .win_host_o   (win_host),
        .win_addr_o   (win_addr),
        .win_we_o     (win_we),
        .win_be_o     (win_be),
        .win_wdata_o  (win_wdata)
    );

    addr_decoder #(.SRAM_WORDS(SRAM_WORDS)) i_addr_decoder (
        .win_req_i  (win_req),
        .win_addr_i (win_addr),
        .sram_req_o (sram_req),
        .gpio_req_o (gpio_req),
        .illegal_o  (illegal)
    );

    //////////////////////////////////////////////////
    // Targets
    //////////////////////////////////////////////////

    sram_bank #(.SRAM_WORDS(SRAM_WORDS)) i_sram_bank (
        .clk_i      (clk_i),
        .sram_req_i (sram_req),
        .addr_i     (win_addr),
        .we_i       (win_we),
        .be_i       (win_be),
        .wdata_i    (win_wdata),
        .rdata_o    (sram_rdata)
    );

    gpio_regs #(.NUM_GPIO(NUM_GPIO)) i_gpio_regs (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .gpio_req_i  (gpio_req),
        .addr_i      (win_addr),
        .we_i        (win_we),
        .wdata_i     (win_wdata),
        .illegal_i   (illegal),
        .rdata_o     (gpio_rdata),
        .gpio_i      (gpio_i),
        .gpio_o      (gpio_o),
        .gpio_oeb_no (gpio_oeb_no)
    );

    // Response return
    response_mux i_response_mux (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .accept_i      (win_req),
        .win_host_i    (win_host),
        .sram_req_i    (sram_req),
        .gpio_req_i    (gpio_req),
        .sram_rdata_i  (sram_rdata),
        .gpio_rdata_i  (gpio_rdata),
        .core_rvalid_o (core_rvalid_o),
        .core_rdata_o  (core_rdata_o),
        .host_rvalid_o (host_rvalid_o),
        .host_rdata_o  (host_rdata_o)
    );

endmodule

// File: hw/response_mux.sv
`timescale 1ns/1ps

module response_mux (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  logic                       accept_i,
    input  logic                       win_host_i,
    input  logic                       sram_req_i,
    input  logic                       gpio_req_i,
    input  logic [soc_pkg::DATA_W-1:0] sram_rdata_i,
    input  logic [soc_pkg::DATA_W-1:0] gpio_rdata_i,

    output logic                       core_rvalid_o,
    output logic [soc_pkg::DATA_W-1:0] core_rdata_o,
    output logic                       host_rvalid_o,
    output logic [soc_pkg::DATA_W-1:0] host_rdata_o
);
    import soc_pkg::*;

    // Response source encoding
    localparam logic [1:0] SRC_SRAM = 2'd0;
    localparam logic [1:0] SRC_GPIO = 2'd1;
    localparam logic [1:0] SRC_ERR  = 2'd2;

    logic              valid_q;
    logic              host_q;
    logic [1:0]        src_q;
    logic [DATA_W-1:0] rdata_sel;

    // Capture owner and source at acceptance
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= 1'b0;
            host_q  <= 1'b0;
            src_q   <= SRC_ERR;
        end else begin
            valid_q <= accept_i;
            if (accept_i) begin
                host_q <= win_host_i;
                if (sram_req_i) begin
                    src_q <= SRC_SRAM;
                end else if (gpio_req_i) begin
                    src_q <= SRC_GPIO;
                end else begin
                    src_q <= SRC_ERR;
                end
            end
        end
    end

    always_comb begin
        case (src_q)
            SRC_SRAM: rdata_sel = sram_rdata_i;
            SRC_GPIO: rdata_sel = gpio_rdata_i;
            default:  rdata_sel = ERR_RDATA;
        endcase
    end

    // Steer the response back to whoever was granted
    assign core_rvalid_o = valid_q & ~host_q;
    assign host_rvalid_o = valid_q & host_q;
    assign core_rdata_o  = rdata_sel;
    assign host_rdata_o  = rdata_sel;

endmodule

// File: hw/gpio_regs.sv
`timescale 1ns/1ps

module gpio_regs #(
    parameter int unsigned NUM_GPIO = 24
) (
    input  logic                       clk_i,
    input  logic                       rst_n_i,

    input  logic                       gpio_req_i,
    input  logic [soc_pkg::DATA_W-1:0] addr_i,
    input  logic                       we_i,
    input  logic [soc_pkg::DATA_W-1:0] wdata_i,
    input  logic                       illegal_i,

    output logic [soc_pkg::DATA_W-1:0] rdata_o,

    // Pads
    input  logic [NUM_GPIO-1:0]        gpio_i,
    output logic [NUM_GPIO-1:0]        gpio_o,
    output logic [NUM_GPIO-1:0]        gpio_oeb_no
);
    import soc_pkg::*;

    logic [NUM_GPIO-1:0] gpio_out_q;
    logic [NUM_GPIO-1:0] gpio_oeb_q;
    logic [NUM_GPIO-1:0] gpio_in_q;
    logic [DATA_W-1:0]   err_count_q;
    logic [3:0]          offset;
    logic                wr_en;

    assign offset = addr_i[3:0];
    assign wr_en  = gpio_req_i & we_i;

    //////////////////////////////////////////////////
    // Control registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            gpio_out_q  <= '0;
            gpio_oeb_q  <= '1;
            err_count_q <= '0;
        end else begin
            if (wr_en && offset == REG_GPIO_OUT) begin
                gpio_out_q <= wdata_i[NUM_GPIO-1:0];
            end
            if (wr_en && offset == REG_GPIO_OEB) begin
                gpio_oeb_q <= wdata_i[NUM_GPIO-1:0];
            end
            // Saturates at all ones
            if (illegal_i && err_count_q != '1) begin
                err_count_q <= err_count_q + 1'b1;
            end
        end
    end

    // Pin sampling and read data
    always_ff @(posedge clk_i) begin
        gpio_in_q <= gpio_i;
        if (gpio_req_i) begin
            rdata_o <= '0;
            if (!we_i) begin
                case (offset)
                    REG_GPIO_OUT:  rdata_o <= DATA_W'(gpio_out_q);
                    REG_GPIO_OEB:  rdata_o <= DATA_W'(gpio_oeb_q);
                    REG_GPIO_IN:   rdata_o <= DATA_W'(gpio_in_q);
                    REG_ERR_COUNT: rdata_o <= err_count_q;
                    default:       rdata_o <= '0;
                endcase
            end
        end
    end

    assign gpio_o      = gpio_out_q;
    assign gpio_oeb_no = gpio_oeb_q;

endmodule

// File: hw/sram_bank.sv
`timescale 1ns/1ps

module sram_bank #(
    parameter int unsigned SRAM_WORDS = 256
) (
    input  logic                       clk_i,

    input  logic                       sram_req_i,
    input  logic [soc_pkg::DATA_W-1:0] addr_i,
    input  logic                       we_i,
    input  logic [soc_pkg::BE_W-1:0]   be_i,
    input  logic [soc_pkg::DATA_W-1:0] wdata_i,

    output logic [soc_pkg::DATA_W-1:0] rdata_o
);
    import soc_pkg::*;

    localparam int unsigned IDX_W = $clog2(SRAM_WORDS);

    logic [DATA_W-1:0] mem [SRAM_WORDS];
    logic [IDX_W-1:0]  word_idx;

    // Word select, byte offset ignored
    assign word_idx = addr_i[IDX_W+1:2];

    //////////////////////////////////////////////////
    // Array access
    //////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (sram_req_i) begin
            if (we_i) begin
                for (int b = 0; b < BE_W; b++) begin
                    if (be_i[b]) begin
                        mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
                    end
                end
                // Writes answer with zero
                rdata_o <= '0;
            end else begin
                rdata_o <= mem[word_idx];
            end
        end
    end

endmodule

// File: hw/addr_decoder.sv
`timescale 1ns/1ps

module addr_decoder #(
    parameter int unsigned SRAM_WORDS = 256
) (
    input  logic                       win_req_i,
    input  logic [soc_pkg::DATA_W-1:0] win_addr_i,

    output logic                       sram_req_o,
    output logic                       gpio_req_o,
    output logic                       illegal_o
);
    import soc_pkg::*;

    // Window ends, both exclusive
    localparam logic [DATA_W-1:0] SRAM_END   = SRAM_BASE + DATA_W'(SRAM_WORDS * 4);
    localparam logic [DATA_W-1:0] PERIPH_END = PERIPH_BASE + DATA_W'(16);

    logic in_sram;
    logic in_gpio;

    assign in_sram = (win_addr_i >= SRAM_BASE) && (win_addr_i < SRAM_END);
    assign in_gpio = (win_addr_i >= PERIPH_BASE) && (win_addr_i < PERIPH_END);

    //////////////////////////////////////////////////
    // One-hot target select
    //////////////////////////////////////////////////

    always_comb begin
        sram_req_o = 1'b0;
        gpio_req_o = 1'b0;
        illegal_o  = 1'b0;
        if (win_req_i) begin
            if (in_sram) begin
                sram_req_o = 1'b1;
            end else if (in_gpio) begin
                gpio_req_o = 1'b1;
            end else begin
                // Unmapped, answered by the error responder
                illegal_o = 1'b1;
            end
        end
    end

endmodule

// File: hw/obi_priority_mux.sv
`timescale 1ns/1ps

module obi_priority_mux (
    input  logic                       host_en_i,

    // Core data port
    input  logic                       core_req_i,
    output logic                       core_gnt_o,
    input  logic [soc_pkg::DATA_W-1:0] core_addr_i,
    input  logic                       core_we_i,
    input  logic [soc_pkg::BE_W-1:0]   core_be_i,
    input  logic [soc_pkg::DATA_W-1:0] core_wdata_i,

    // Host port
    input  logic                       host_req_i,
    output logic                       host_gnt_o,
    input  logic [soc_pkg::DATA_W-1:0] host_addr_i,
    input  logic                       host_we_i,
    input  logic [soc_pkg::BE_W-1:0]   host_be_i,
    input  logic [soc_pkg::DATA_W-1:0] host_wdata_i,

    // Winning request
    output logic                       win_req_o,
    output logic                       win_host_o,
    output logic [soc_pkg::DATA_W-1:0] win_addr_o,
    output logic                       win_we_o,
    output logic [soc_pkg::BE_W-1:0]   win_be_o,
    output logic [soc_pkg::DATA_W-1:0] win_wdata_o
);
    import soc_pkg::*;

    logic              host_req_gated;
    logic [DATA_W-1:0] host_addr_remap;

    // Host is invisible while disabled
    assign host_req_gated = host_req_i & host_en_i;

    // Fold 0x3xxx_xxxx..0x7xxx_xxxx onto the SRAM window
    always_comb begin
        host_addr_remap = host_addr_i;
        if (host_addr_i >= REMAP_LO && host_addr_i < REMAP_HI) begin
            host_addr_remap = {4'h8, host_addr_i[DATA_W-5:0]};
        end
    end

    // Targets are always ready, so gnt follows req in the same cycle
    assign host_gnt_o = host_req_gated;
    assign core_gnt_o = core_req_i & ~host_req_gated;

    assign win_req_o   = host_req_gated | core_req_i;
    assign win_host_o  = host_req_gated;
    assign win_addr_o  = host_req_gated ? host_addr_remap : core_addr_i;
    assign win_we_o    = host_req_gated ? host_we_i       : core_we_i;
    assign win_be_o    = host_req_gated ? host_be_i       : core_be_i;
    assign win_wdata_o = host_req_gated ? host_wdata_i    : core_wdata_i;

endmodule

// File: hw/soc_pkg.sv
package soc_pkg;

    //////////////////////////////////////////////////
    // Bus widths
    //////////////////////////////////////////////////

    localparam int unsigned DATA_W = 32;
    localparam int unsigned BE_W   = DATA_W / 8;

    //////////////////////////////////////////////////
    // Address map
    //////////////////////////////////////////////////

    localparam logic [DATA_W-1:0] SRAM_BASE   = 32'h8000_0000;
    localparam logic [DATA_W-1:0] PERIPH_BASE = 32'h2000_0000;

    // Host window folded onto the SRAM, upper bound exclusive
    localparam logic [DATA_W-1:0] REMAP_LO = 32'h3000_0000;
    localparam logic [DATA_W-1:0] REMAP_HI = 32'h8000_0000;

    // GPIO register offsets
    localparam logic [3:0] REG_GPIO_OUT  = 4'h0;
    localparam logic [3:0] REG_GPIO_OEB  = 4'h4;
    localparam logic [3:0] REG_GPIO_IN   = 4'h8;
    localparam logic [3:0] REG_ERR_COUNT = 4'hC;

    // Data returned on unmapped accesses
    localparam logic [DATA_W-1:0] ERR_RDATA = '0;

endpackage
